// ==== rtl/robPkg.sv ====
package robPkg;

    localparam int idLen    = 4;
    localparam int robSize  = 1 << idLen;
    localparam int sqnLen   = idLen + 1;
    localparam int decWidth = 2;
    localparam int retWidth = 2;
    localparam int wbWidth  = 2;
    localparam int tagLen   = 6;
    localparam int rdLen    = 5;

    // Ordinary completions sort lowest, trap class sorts highest
    typedef enum logic [3:0] {
        flagNone, flagBranch, flagPredTaken, flagPredNotTaken,
        flagFpNx, flagFpUf, flagFpOf, flagFpNv,
        flagNotExec,
        flagFence, flagIllegal, flagLoadFault, flagTrap
    } Flags;

    typedef enum logic [1:0] {fuInt, fuFpu, fuRename, fuTrap} FuType;

    localparam logic [tagLen-1:0] invalidTag = '1;

    function automatic logic isTrapFlag(Flags f);
        return f >= flagFence;
    endfunction

    function automatic logic isBranchFlag(Flags f);
        return f == flagBranch || f == flagPredTaken || f == flagPredNotTaken;
    endfunction

    function automatic logic isFpFlag(Flags f);
        return f >= flagFpNx && f <= flagFpNv;
    endfunction

    // Age check on wrapping sequence numbers
    function automatic logic sqnYounger(logic [sqnLen-1:0] a, logic [sqnLen-1:0] b);
        logic [sqnLen-1:0] diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

// ==== rtl/renameSorter.sv ====
`timescale 1ns/1ps

module renameSorter (
    input  logic [robPkg::decWidth-1:0] uopValid,
    input  logic [robPkg::sqnLen-1:0]   uopSqN[robPkg::decWidth-1:0],
    input  logic [robPkg::tagLen-1:0]   uopTag[robPkg::decWidth-1:0],
    input  logic [robPkg::rdLen-1:0]    uopRd[robPkg::decWidth-1:0],
    input  robPkg::FuType               uopFu[robPkg::decWidth-1:0],
    output logic [robPkg::decWidth-1:0] slotValid,
    output logic [robPkg::sqnLen-1:0]   slotSqN[robPkg::decWidth-1:0],
    output logic [robPkg::tagLen-1:0]   slotTag[robPkg::decWidth-1:0],
    output logic [robPkg::rdLen-1:0]    slotRd[robPkg::decWidth-1:0],
    output robPkg::FuType               slotFu[robPkg::decWidth-1:0]
);
    import robPkg::*;

    // Output slot i takes the uop whose sqN low bit equals i
    always_comb begin
        for (int i = 0; i < decWidth; i++) begin
            slotValid[i] = 1'b0;
            slotSqN[i]   = '0;
            slotTag[i]   = '0;
            slotRd[i]    = '0;
            slotFu[i]    = fuInt;
            for (int j = 0; j < decWidth; j++) begin
                if (uopValid[j] && uopSqN[j][0] == 1'(i)) begin
                    slotValid[i] = 1'b1;
                    slotSqN[i]   = uopSqN[j];
                    slotTag[i]   = uopTag[j];
                    slotRd[i]    = uopRd[j];
                    slotFu[i]    = uopFu[j];
                end
            end
        end
    end

endmodule

// ==== rtl/robStorage.sv ====
`timescale 1ns/1ps

module robStorage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [robPkg::decWidth-1:0] slotValid,
    input  logic [robPkg::sqnLen-1:0]   slotSqN[robPkg::decWidth-1:0],
    input  logic [robPkg::tagLen-1:0]   slotTag[robPkg::decWidth-1:0],
    input  logic [robPkg::rdLen-1:0]    slotRd[robPkg::decWidth-1:0],
    input  robPkg::FuType               slotFu[robPkg::decWidth-1:0],
    input  logic [robPkg::wbWidth-1:0]  wbValid,
    input  logic [robPkg::sqnLen-1:0]   wbSqN[robPkg::wbWidth-1:0],
    input  robPkg::Flags                wbFlags[robPkg::wbWidth-1:0],
    input  logic                        branchTaken,
    input  logic [robPkg::sqnLen-1:0]   branchSqN,
    input  logic [robPkg::idLen-1:0]    readBase,
    input  logic [robPkg::retWidth-1:0] retireMask,
    output logic [robPkg::retWidth-1:0] readValid,
    output robPkg::Flags                readFlags[robPkg::retWidth-1:0],
    output logic [robPkg::tagLen-1:0]   readTag[robPkg::retWidth-1:0],
    output logic [robPkg::rdLen-1:0]    readRd[robPkg::retWidth-1:0],
    output logic [robPkg::retWidth-1:0] readIsFp,
    output logic [robPkg::retWidth-1:0] readSqnMsb
);
    import robPkg::*;

    logic [robSize-1:0] entValid;
    Flags               entFlags[robSize-1:0];
    logic [tagLen-1:0]  entTag[robSize-1:0];
    logic [rdLen-1:0]   entRd[robSize-1:0];
    logic [robSize-1:0] entIsFp;
    logic [robSize-1:0] entMsb;

    logic [robSize-1:0]  entYounger;
    logic [decWidth-1:0] enqOk;
    logic [idLen-1:0]    enqIdx[decWidth-1:0];
    logic [wbWidth-1:0]  wbOk;

    logic [idLen-1:0] readAddr[retWidth-1:0];
    logic [idLen-2:0] bankRow[retWidth-1:0];
    logic [idLen-1:0] bankIdx[retWidth-1:0];

    always_comb begin
        for (int k = 0; k < robSize; k++) begin
            entYounger[k] = sqnYounger({entMsb[k], idLen'(k)}, branchSqN);
        end
        // Writes from the same cycle as a taken branch only count up to the branch
        for (int i = 0; i < decWidth; i++) begin
            enqOk[i]  = slotValid[i] && !(branchTaken && sqnYounger(slotSqN[i], branchSqN));
            enqIdx[i] = {slotSqN[i][idLen-1:1], 1'(i)};
        end
        for (int i = 0; i < wbWidth; i++) begin
            wbOk[i] = wbValid[i] && !(branchTaken && sqnYounger(wbSqN[i], branchSqN));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entValid <= '0;
        end else begin
            for (int i = 0; i < retWidth; i++) begin
                if (retireMask[i]) entValid[readBase + idLen'(i)] <= 1'b0;
            end
            if (branchTaken) entValid <= entValid & ~entYounger;
            for (int i = 0; i < decWidth; i++) begin
                if (enqOk[i]) entValid[enqIdx[i]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < decWidth; i++) begin
            if (enqOk[i]) begin
                entTag[enqIdx[i]]  <= slotTag[i];
                entRd[enqIdx[i]]   <= slotRd[i];
                entIsFp[enqIdx[i]] <= slotFu[i] == fuFpu;
                entMsb[enqIdx[i]]  <= slotSqN[i][idLen];
                entFlags[enqIdx[i]] <= slotFu[i] == fuRename ? flagNone :
                                       slotFu[i] == fuTrap ? flagTrap : flagNotExec;
            end
        end
        for (int i = 0; i < wbWidth; i++) begin
            if (wbOk[i]) entFlags[wbSqN[i][idLen-1:0]] <= wbFlags[i];
        end
    end

    // Two consecutive reads always hit different banks
    always_comb begin
        for (int i = 0; i < retWidth; i++) begin
            readAddr[i] = readBase + idLen'(i);
            bankRow[i]  = '0;
        end
        for (int i = 0; i < retWidth; i++) begin
            bankRow[readAddr[i][0]] = readAddr[i][idLen-1:1];
        end
        for (int b = 0; b < retWidth; b++) begin
            bankIdx[b] = {bankRow[b], 1'(b)};
        end
        // Back into program order
        for (int i = 0; i < retWidth; i++) begin
            readValid[i]  = entValid[bankIdx[readAddr[i][0]]];
            readFlags[i]  = entFlags[bankIdx[readAddr[i][0]]];
            readTag[i]    = entTag[bankIdx[readAddr[i][0]]];
            readRd[i]     = entRd[bankIdx[readAddr[i][0]]];
            readIsFp[i]   = entIsFp[bankIdx[readAddr[i][0]]];
            readSqnMsb[i] = entMsb[bankIdx[readAddr[i][0]]];
        end
    end

endmodule

// ==== rtl/retireUnit.sv ====
`timescale 1ns/1ps

module retireUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        branchTaken,
    input  logic [robPkg::sqnLen-1:0]   branchSqN,
    input  logic [robPkg::retWidth-1:0] readValid,
    input  robPkg::Flags                readFlags[robPkg::retWidth-1:0],
    input  logic [robPkg::tagLen-1:0]   readTag[robPkg::retWidth-1:0],
    input  logic [robPkg::rdLen-1:0]    readRd[robPkg::retWidth-1:0],
    input  logic [robPkg::retWidth-1:0] readIsFp,
    input  logic [robPkg::retWidth-1:0] readSqnMsb,
    output logic [robPkg::idLen-1:0]    readBase,
    output logic [robPkg::retWidth-1:0] retireMask,
    output logic [robPkg::sqnLen-1:0]   curSqN,
    output logic [robPkg::sqnLen-1:0]   maxSqN,
    output logic [robPkg::retWidth-1:0] comValid,
    output logic [robPkg::rdLen-1:0]    comRd[robPkg::retWidth-1:0],
    output logic [robPkg::tagLen-1:0]   comTag[robPkg::retWidth-1:0],
    output logic [robPkg::sqnLen-1:0]   comSqN[robPkg::retWidth-1:0],
    output logic [robPkg::retWidth-1:0] comIsBranch,
    output logic                        trapValid,
    output robPkg::Flags                trapFlags,
    output logic [robPkg::sqnLen-1:0]   trapSqN,
    output logic [robPkg::rdLen-1:0]    trapRd,
    output logic [3:0]                  fpNewFlags,
    output logic                        mispredFlush
);
    import robPkg::*;

    typedef enum logic [1:0] {retireIdle, retireStall, retireReplay} RetireState;

    RetireState        state;
    logic [sqnLen-1:0] replayIter;
    logic [sqnLen-1:0] replayEnd;

    logic [retWidth-1:0] retireOk;
    logic [retWidth-1:0] trapHit;
    logic [retWidth-1:0] replayIn;
    logic                replayLast;
    logic [sqnLen-1:0]   slotSqN[retWidth-1:0];

    assign maxSqN   = curSqN + sqnLen'(robSize - 1);
    assign readBase = state == retireReplay ? replayIter[idLen-1:0] : curSqN[idLen-1:0];

    always_comb begin
        logic groupDone;
        groupDone = 1'b0;
        retireOk  = '0;
        trapHit   = '0;
        for (int i = 0; i < retWidth; i++) begin
            slotSqN[i]  = {readSqnMsb[i], readBase + idLen'(i)};
            replayIn[i] = !sqnYounger(replayIter + sqnLen'(i), replayEnd);
            // Strictly in order, a trap closes the group
            if (!groupDone && readValid[i] && readFlags[i] != flagNotExec) begin
                retireOk[i] = 1'b1;
                if (isTrapFlag(readFlags[i])) begin
                    trapHit[i] = 1'b1;
                    groupDone  = 1'b1;
                end
            end else begin
                groupDone = 1'b1;
            end
        end
        replayLast = !sqnYounger(replayEnd, replayIter + sqnLen'(retWidth - 1));
        retireMask = (state == retireIdle && !branchTaken) ? retireOk : '0;
    end

    always_ff @(posedge clk) begin
        comValid     <= '0;
        trapValid    <= 1'b0;
        fpNewFlags   <= '0;
        mispredFlush <= 1'b0;
        if (rst) begin
            state  <= retireIdle;
            curSqN <= '0;
        end else if (branchTaken) begin
            state      <= retireReplay;
            replayIter <= curSqN;
            replayEnd  <= branchSqN;
        end else begin
            case (state)
                retireIdle: begin
                    for (int i = 0; i < retWidth; i++) begin
                        if (retireMask[i]) begin
                            comValid[i]    <= 1'b1;
                            comRd[i]       <= readRd[i];
                            comTag[i]      <= readTag[i];
                            comSqN[i]      <= slotSqN[i];
                            comIsBranch[i] <= isBranchFlag(readFlags[i]);
                            if (trapHit[i]) begin
                                trapValid <= 1'b1;
                                trapFlags <= readFlags[i];
                                trapSqN   <= slotSqN[i];
                                trapRd    <= readRd[i];
                                state     <= retireStall;
                                // Faulting result goes nowhere
                                if (readFlags[i] == flagIllegal ||
                                    readFlags[i] == flagLoadFault) begin
                                    comRd[i]  <= '0;
                                    comTag[i] <= invalidTag;
                                end
                            end else if (readIsFp[i] && isFpFlag(readFlags[i])) begin
                                fpNewFlags[2'(readFlags[i] - flagFpNx)] <= 1'b1;
                                // UF and OF imply NX (bit 0)
                                if (readFlags[i] == flagFpUf || readFlags[i] == flagFpOf) begin
                                    fpNewFlags[0] <= 1'b1;
                                end
                            end
                        end
                    end
                    curSqN <= curSqN + sqnLen'($countones(retireMask));
                end
                retireStall: state <= retireIdle;
                retireReplay: begin
                    mispredFlush <= 1'b1;
                    for (int i = 0; i < retWidth; i++) begin
                        if (replayIn[i]) begin
                            comValid[i]    <= 1'b1;
                            comRd[i]       <= readRd[i];
                            comTag[i]      <= readTag[i];
                            comSqN[i]      <= replayIter + sqnLen'(i);
                            comIsBranch[i] <= 1'b0;
                        end
                    end
                    replayIter <= replayIter + sqnLen'(retWidth);
                    if (replayLast) state <= retireIdle;
                end
                default: state <= retireIdle;
            endcase
        end
    end

endmodule

// ==== rtl/robTop.sv ====
`timescale 1ns/1ps

module robTop (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [robPkg::decWidth-1:0] uopValid,
    input  logic [robPkg::sqnLen-1:0]   uopSqN[robPkg::decWidth-1:0],
    input  logic [robPkg::tagLen-1:0]   uopTag[robPkg::decWidth-1:0],
    input  logic [robPkg::rdLen-1:0]    uopRd[robPkg::decWidth-1:0],
    input  robPkg::FuType               uopFu[robPkg::decWidth-1:0],
    input  logic [robPkg::wbWidth-1:0]  wbValid,
    input  logic [robPkg::sqnLen-1:0]   wbSqN[robPkg::wbWidth-1:0],
    input  robPkg::Flags                wbFlags[robPkg::wbWidth-1:0],
    input  logic                        branchTaken,
    input  logic [robPkg::sqnLen-1:0]   branchSqN,
    output logic [robPkg::sqnLen-1:0]   curSqN,
    output logic [robPkg::sqnLen-1:0]   maxSqN,
    output logic [robPkg::retWidth-1:0] comValid,
    output logic [robPkg::rdLen-1:0]    comRd[robPkg::retWidth-1:0],
    output logic [robPkg::tagLen-1:0]   comTag[robPkg::retWidth-1:0],
    output logic [robPkg::sqnLen-1:0]   comSqN[robPkg::retWidth-1:0],
    output logic [robPkg::retWidth-1:0] comIsBranch,
    output logic                        trapValid,
    output robPkg::Flags                trapFlags,
    output logic [robPkg::sqnLen-1:0]   trapSqN,
    output logic [robPkg::rdLen-1:0]    trapRd,
    output logic [3:0]                  fpNewFlags,
    output logic                        mispredFlush
);
    import robPkg::*;

    logic [decWidth-1:0] slotValid;
    logic [sqnLen-1:0]   slotSqN[decWidth-1:0];
    logic [tagLen-1:0]   slotTag[decWidth-1:0];
    logic [rdLen-1:0]    slotRd[decWidth-1:0];
    FuType               slotFu[decWidth-1:0];

    logic [retWidth-1:0] readValid;
    Flags                readFlags[retWidth-1:0];
    logic [tagLen-1:0]   readTag[retWidth-1:0];
    logic [rdLen-1:0]    readRd[retWidth-1:0];
    logic [retWidth-1:0] readIsFp;
    logic [retWidth-1:0] readSqnMsb;
    logic [idLen-1:0]    readBase;
    logic [retWidth-1:0] retireMask;

    renameSorter renameSorter_inst (.*);

    robStorage robStorage_inst (.*);

    retireUnit retireUnit_inst (.*);

endmodule

// ==== testbench/robTb.sv ====
`timescale 1ns/1ps

module robTb;
    import robPkg::*;

    localparam int clkPeriod   = 8;
    localparam int randCycles  = 300;
    localparam int branchRuns  = 6;
    localparam int runCycles   = 20;
    localparam int waitLimit   = 60;
    localparam int drainLimit  = 200;
    localparam int totalCycles = 4 + randCycles
        + branchRuns * (runCycles + 1 + 2 * waitLimit) + drainLimit;

    logic                clk;
    logic                rst;
    logic [decWidth-1:0] uopValid;
    logic [sqnLen-1:0]   uopSqN[decWidth-1:0];
    logic [tagLen-1:0]   uopTag[decWidth-1:0];
    logic [rdLen-1:0]    uopRd[decWidth-1:0];
    FuType               uopFu[decWidth-1:0];
    logic [wbWidth-1:0]  wbValid;
    logic [sqnLen-1:0]   wbSqN[wbWidth-1:0];
    Flags                wbFlags[wbWidth-1:0];
    logic                branchTaken;
    logic [sqnLen-1:0]   branchSqN;
    logic [sqnLen-1:0]   curSqN;
    logic [sqnLen-1:0]   maxSqN;
    logic [retWidth-1:0] comValid;
    logic [rdLen-1:0]    comRd[retWidth-1:0];
    logic [tagLen-1:0]   comTag[retWidth-1:0];
    logic [sqnLen-1:0]   comSqN[retWidth-1:0];
    logic [retWidth-1:0] comIsBranch;
    logic                trapValid;
    Flags                trapFlags;
    logic [sqnLen-1:0]   trapSqN;
    logic [rdLen-1:0]    trapRd;
    logic [3:0]          fpNewFlags;
    logic                mispredFlush;

    robTop robTop_inst (.*);

    // Reference model, indexed by the low sqN bits
    logic [rdLen-1:0]  mRd[robSize];
    logic [tagLen-1:0] mTag[robSize];
    FuType             mFu[robSize];
    Flags              mFlag[robSize];
    logic [sqnLen-1:0] nextSqN;
    logic [sqnLen-1:0] issueSqN;
    logic [sqnLen-1:0] pending[$];
    logic [sqnLen-1:0] flushBase;
    logic              prevTrap;
    logic              prevFlush;
    int                flushCnt;
    int                flushExp;
    int                errors;
    int                seed;

    logic [sqnLen-1:0]   expSqN[retWidth];
    logic [rdLen-1:0]    expRd[retWidth];
    logic [tagLen-1:0]   expTag[retWidth];
    Flags                expFlag[retWidth];
    logic [retWidth-1:0] expBranch;
    logic [3:0]          expFp;
    logic [sqnLen-1:0]   expTrapSqN;
    logic [sqnLen-1:0]   expMax;

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always_comb begin
        expFp = '0;
        for (int i = 0; i < retWidth; i++) begin
            expSqN[i]    = nextSqN + sqnLen'(i);
            expFlag[i]   = mFlag[expSqN[i][idLen-1:0]];
            expRd[i]     = mRd[expSqN[i][idLen-1:0]];
            expTag[i]    = mTag[expSqN[i][idLen-1:0]];
            expBranch[i] = expFlag[i] inside {flagBranch, flagPredTaken, flagPredNotTaken};
            if (expFlag[i] == flagIllegal || expFlag[i] == flagLoadFault) begin
                expRd[i]  = '0;
                expTag[i] = '1;
            end
            // NX UF OF NV from bit 0 up, UF and OF drag NX along
            if (comValid[i] && mFu[expSqN[i][idLen-1:0]] == fuFpu) begin
                case (expFlag[i])
                    flagFpNx: expFp = expFp | 4'b0001;
                    flagFpUf: expFp = expFp | 4'b0011;
                    flagFpOf: expFp = expFp | 4'b0101;
                    flagFpNv: expFp = expFp | 4'b1000;
                    default: ;
                endcase
            end
        end
        expTrapSqN = comValid[1] ? expSqN[1] : expSqN[0];
        // Window end counts the entries retired in this cycle
        expMax = nextSqN + sqnLen'(mispredFlush ? 0 : $countones(comValid))
            + sqnLen'(robSize - 1);
    end

    task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic reportProblem(string what);
        errors++;
        $display("[FAIL] %0t %s", $time, what);
    endtask

    resetIdle: assert property (@(negedge clk) rst |-> (comValid == '0 && !trapValid
        && fpNewFlags == '0 && !mispredFlush && curSqN == '0))
        else reportProblem("outputs not cleared by reset");

    for (genvar g = 0; g < retWidth; g++) begin : slotChecks
        orderChk: assert property (@(negedge clk) disable iff (rst)
            comValid[g] && !mispredFlush |-> comSqN[g] == expSqN[g])
            else reportMismatch($sformatf("comSqN[%0d]", g), comSqN[g], $sampled(expSqN[g]));
        rdChk: assert property (@(negedge clk) disable iff (rst)
            comValid[g] && !mispredFlush |-> comRd[g] == expRd[g])
            else reportMismatch($sformatf("comRd[%0d]", g), comRd[g], $sampled(expRd[g]));
        tagChk: assert property (@(negedge clk) disable iff (rst)
            comValid[g] && !mispredFlush |-> comTag[g] == expTag[g])
            else reportMismatch($sformatf("comTag[%0d]", g), comTag[g], $sampled(expTag[g]));
        branchChk: assert property (@(negedge clk) disable iff (rst)
            comValid[g] && !mispredFlush |-> comIsBranch[g] == expBranch[g])
            else reportMismatch($sformatf("comIsBranch[%0d]", g), comIsBranch[g],
                                $sampled(expBranch[g]));
        execChk: assert property (@(negedge clk) disable iff (rst)
            comValid[g] && !mispredFlush |-> expFlag[g] != flagNotExec)
            else reportProblem("an entry retired before its writeback");
    end

    slotGap: assert property (@(negedge clk) disable iff (rst) comValid != 2'b10)
        else reportProblem("slot 1 committed without slot 0");
    trapSqChk: assert property (@(negedge clk) disable iff (rst)
        trapValid |-> trapSqN == expTrapSqN)
        else reportMismatch("trapSqN", trapSqN, $sampled(expTrapSqN));
    trapRdChk: assert property (@(negedge clk) disable iff (rst)
        trapValid |-> trapRd == mRd[expTrapSqN[idLen-1:0]])
        else reportMismatch("trapRd", trapRd, $sampled(mRd[expTrapSqN[idLen-1:0]]));
    trapFlagChk: assert property (@(negedge clk) disable iff (rst)
        trapValid |-> trapFlags == mFlag[expTrapSqN[idLen-1:0]])
        else reportMismatch("trapFlags", trapFlags, $sampled(mFlag[expTrapSqN[idLen-1:0]]));
    trapRaised: assert property (@(negedge clk) disable iff (rst) comValid != '0
        && !mispredFlush && mFlag[expTrapSqN[idLen-1:0]] >= flagFence |-> trapValid)
        else reportProblem("trap-class entry retired without trapValid");
    stallChk: assert property (@(negedge clk) disable iff (rst) prevTrap |-> comValid == '0)
        else reportProblem("an entry retired in the cycle after a trap");
    fpChk: assert property (@(negedge clk) disable iff (rst) !mispredFlush |-> fpNewFlags == expFp)
        else reportMismatch("fpNewFlags", fpNewFlags, $sampled(expFp));
    baseHold: assert property (@(negedge clk) disable iff (rst) mispredFlush |-> curSqN == flushBase)
        else reportMismatch("curSqN", curSqN, $sampled(flushBase));
    maxChk: assert property (@(negedge clk) disable iff (rst) maxSqN == expMax)
        else reportMismatch("maxSqN", maxSqN, $sampled(expMax));
    replayCount: assert property (@(negedge clk) disable iff (rst)
        prevFlush && !mispredFlush |-> flushCnt == flushExp)
        else reportMismatch("replay slot count", flushCnt, $sampled(flushExp));

    function automatic int rnd(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Track what the DUT showed in this cycle
    task automatic step();
        @(negedge clk);
        if (mispredFlush) flushCnt += $countones(comValid);
        else if (comValid[1]) nextSqN += 2;
        else if (comValid[0]) nextSqN += 1;
        prevTrap    = trapValid;
        prevFlush   = mispredFlush;
        uopValid    = '0;
        wbValid     = '0;
        branchTaken = 1'b0;
    endtask

    function automatic Flags pickFlag(FuType fu, bit allowTraps);
        if (fu == fuFpu) begin
            case (rnd(5))
                0: return flagFpNx;
                1: return flagFpUf;
                2: return flagFpOf;
                3: return flagFpNv;
                default: return flagNone;
            endcase
        end
        if (allowTraps && rnd(20) == 0) return flagIllegal;
        // Integer results may carry FP flags too, which must not reach fpNewFlags
        return Flags'(rnd(8));
    endfunction

    task automatic traffic(bit allowTraps, bit allowRename);
        logic [sqnLen-1:0] s;
        logic [sqnLen-1:0] span;
        int k;
        int r;
        for (int p = 0; p < wbWidth; p++) begin
            if (pending.size() > 0 && rnd(2) == 0) begin
                k = rnd(pending.size());
                s = pending[k];
                pending.delete(k);
                wbValid[p] = 1'b1;
                wbSqN[p]   = s;
                wbFlags[p] = pickFlag(mFu[s[idLen-1:0]], allowTraps);
                mFlag[s[idLen-1:0]] = wbFlags[p];
            end
        end
        if (!allowRename) return;
        k = rnd(3);
        for (int j = 0; j < k; j++) begin
            span = issueSqN - nextSqN;
            if (span < 14) begin
                r = rnd(10);
                s = issueSqN;
                uopValid[j] = 1'b1;
                uopSqN[j]   = s;
                uopRd[j]    = rdLen'(rnd(32));
                uopTag[j]   = tagLen'(rnd(63));
                uopFu[j]    = r < 6 ? fuInt : r < 8 ? fuFpu : r == 8 ? fuRename :
                              allowTraps ? fuTrap : fuInt;
                mRd[s[idLen-1:0]]   = uopRd[j];
                mTag[s[idLen-1:0]]  = uopTag[j];
                mFu[s[idLen-1:0]]   = uopFu[j];
                mFlag[s[idLen-1:0]] = uopFu[j] == fuRename ? flagNone :
                                      uopFu[j] == fuTrap ? flagTrap : flagNotExec;
                if (uopFu[j] == fuInt || uopFu[j] == fuFpu) pending.push_back(s);
                issueSqN = issueSqN + 1'b1;
            end
        end
    endtask

    task automatic mispredict();
        logic [sqnLen-1:0] span;
        logic [sqnLen-1:0] br;
        logic [sqnLen-1:0] keep[$];
        logic [sqnLen-1:0] d;
        int waited;
        span = issueSqN - nextSqN;
        if (span == 0) return;
        br          = nextSqN + sqnLen'(rnd(int'(span)));
        branchTaken = 1'b1;
        branchSqN   = br;
        flushBase   = nextSqN;
        flushExp    = int'(sqnLen'(br - nextSqN)) + 1;
        flushCnt    = 0;
        // Entries younger than the branch are gone
        foreach (pending[i]) begin
            d = pending[i] - br;
            if ($signed(d) <= 0) keep.push_back(pending[i]);
        end
        pending  = keep;
        issueSqN = br + 1'b1;
        waited   = 0;
        do begin
            step();
            waited++;
        end while (!mispredFlush && waited < waitLimit);
        if (!mispredFlush) reportProblem("mispredFlush did not rise after a taken branch");
        waited = 0;
        while (mispredFlush && waited < waitLimit) begin
            step();
            waited++;
        end
        if (mispredFlush) reportProblem("mispredFlush stayed high too long");
    endtask

    initial begin
        seed        = 32'h6b38ff39;
        errors      = 0;
        rst         = 1'b1;
        uopValid    = '0;
        wbValid     = '0;
        branchTaken = 1'b0;
        branchSqN   = '0;
        for (int i = 0; i < decWidth; i++) begin
            uopSqN[i] = '0;
            uopTag[i] = '0;
            uopRd[i]  = '0;
            uopFu[i]  = fuInt;
            wbSqN[i]  = '0;
            wbFlags[i] = flagNone;
        end
        for (int i = 0; i < robSize; i++) begin
            mRd[i]   = '0;
            mTag[i]  = '0;
            mFu[i]   = fuInt;
            mFlag[i] = flagNone;
        end
        nextSqN   = '0;
        issueSqN  = '0;
        flushBase = '0;
        prevTrap  = 1'b0;
        prevFlush = 1'b0;
        flushCnt  = 0;
        flushExp  = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (randCycles) begin
            step();
            traffic(1'b1, 1'b1);
        end
        repeat (branchRuns) begin
            repeat (runCycles) begin
                step();
                traffic(1'b1, 1'b1);
            end
            step();
            mispredict();
        end
        for (int c = 0; c < drainLimit && (pending.size() > 0 || nextSqN != issueSqN); c++) begin
            step();
            traffic(1'b0, 1'b0);
        end
        if (pending.size() > 0 || nextSqN != issueSqN) reportProblem("ROB did not drain");
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(totalCycles * clkPeriod + 500);
        $display("Watchdog expired, simulation did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/robPkg.sv
rtl/renameSorter.sv
rtl/robStorage.sv
rtl/retireUnit.sv
rtl/robTop.sv
testbench/robTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= robTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi

check: run
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
